// File: logic/zuc_sbox_tables.svh
`ifndef ZUC_SBOX_TABLES_SVH
`define ZUC_SBOX_TABLES_SVH

// Entry 0 sits in the most significant byte.
localparam logic [2047:0] SBOX0_TABLE = {
	128'h3e725b47_cae00033_04d15498_09b96dcb,
	128'h7b1bf932_af9d6aa5_b82dfc1d_08530390,
	128'h4d4e8499_e4ced991_ddb68548_8b296eac,
	128'hcdc1f81e_734369c6_b5bdfd39_6320d438,
	128'h767db2a7_cfed57c5_f32cbb14_2106559b,
	128'he3ef5e31_4f7f5aa4_0d825149_5fba581c,
	128'h4a16d517_a892241f_8cffd8ae_2e01d3ad,
	128'h3b4bda46_ebc9de9a_8f87d73a_806f2fc8,
	128'hb1b437f7_0a221328_7ccc3c89_c7c39656,
	128'h07bf7ef0_0b2b9752_35417961_a64c10fe,
	128'hbc269588_8ab0a3fb_c01894f2_e1e5e95d,
	128'hd0dc1166_645cec59_427512f5_749caa23,
	128'h0e86abbe_2a02e767_e644a26c_c2939ff1,
	128'hf6fa36d2_50689e62_71153dd6_40c4e20f,
	128'h8e83776b_25053f0c_30ea70b7_a1e8a965,
	128'h8d271adb_81b3a0f4_457a19df_ee783460
};

localparam logic [2047:0] SBOX1_TABLE = {
	128'h55c26371_3bc84786_9f3cda5b_29aafd77,
	128'h8cc5940c_a61a1300_e3a81672_40f9f842,
	128'h44266896_81d9453e_1076c6a7_8b3943e1,
	128'h3ab5562a_c06db305_2266bfdc_0bfa6248,
	128'hdd201106_36c9c1cf_f62752bb_69f5d487,
	128'h7f844cd2_9c57a4bc_4f9adffe_d68d7aeb,
	128'h2b53d85c_a11417fb_23d57d30_67730809,
	128'heeb7703f_61b2198e_4ee54b93_8f5ddba9,
	128'hadf1ae2e_cb0dfcf4_2d466e1d_97e8d1e9,
	128'h4d37a575_5e839eab_829db91c_e0cd4989,
	128'h01b6bd58_24a25f38_78991590_50b895e4,
	128'hd091c7ce_ed0fb46f_a0ccf002_4a79c3de,
	128'ha3efea51_e66b18ec_1b2c80f7_74e7ff21,
	128'h5a6a541e_41319235_c433070a_ba7e0e34,
	128'h88b1987c_f33d606c_7bcad31f_32650428,
	128'h64be859b_2f598ad7_b025acaf_1203e2f2
};

`endif

// File: logic/zuc_pkg.sv
package zuc_pkg;

	localparam int CELL_W      = 31;
	localparam int WORD_W      = 32;
	localparam int KEY_W       = 128;
	localparam int NUM_CELLS   = 16;
	localparam int INIT_ROUNDS = 32;
	localparam int ROUND_CNT_W = 6;

	// Cycles from the i_init edge to the first o_valid.
	localparam int FIRST_WORD_LAT = 34;

	// D15 is listed first so that index i holds Di.
	localparam logic [NUM_CELLS-1:0][14:0] LOAD_CONST = {
		15'h47AC, 15'h789A, 15'h3C4D, 15'h5E26,
		15'h1AF1, 15'h6BC4, 15'h2F13, 15'h4D78,
		15'h09AF, 15'h7135, 15'h35E2, 15'h5789,
		15'h135E, 15'h626B, 15'h26BC, 15'h44D7
	};

	localparam logic [CELL_W-1:0] CELL_MAX = 31'h7FFF_FFFF;

	typedef logic [CELL_W-1:0] cell_t;
	typedef logic [WORD_W-1:0] word_t;

	typedef struct packed {
		word_t x0;
		word_t x1;
		word_t x2;
		word_t x3;
	} brc_t;

	typedef struct packed {
		logic load;
		logic step;
		logic init_mode;
	} step_ctrl_t;

	typedef enum logic [1:0] {
		PH_IDLE,
		PH_INIT,
		PH_DISCARD,
		PH_STREAM
	} phase_t;

	// Addition modulo 2^31-1 with end-around carry.
	function automatic cell_t add_mod(input cell_t a, input cell_t b);
		logic [CELL_W:0] sum;
		sum = {1'b0, a} + {1'b0, b};
		return sum[CELL_W-1:0] + cell_t'(sum[CELL_W]);
	endfunction

	function automatic cell_t rotl31(input cell_t a, input int unsigned k);
		return (a << k) | (a >> (CELL_W - k));
	endfunction

	function automatic word_t rotl32(input word_t a, input int unsigned k);
		return (a << k) | (a >> (WORD_W - k));
	endfunction

	function automatic word_t l1(input word_t x);
		return x ^ rotl32(x, 2) ^ rotl32(x, 10) ^ rotl32(x, 18) ^ rotl32(x, 24);
	endfunction

	function automatic word_t l2(input word_t x);
		return x ^ rotl32(x, 8) ^ rotl32(x, 14) ^ rotl32(x, 22) ^ rotl32(x, 30);
	endfunction

endpackage

// File: logic/zuc_sbox.sv
`timescale 1ns/1ns

module zuc_sbox #(
	parameter int SEL = 0
) (
	input  logic [7:0] i_byte,
	output logic [7:0] o_byte
);

	`include "zuc_sbox_tables.svh"

	logic [10:0] bit_idx;

	// Entry n lives at bit offset (255 - n) * 8.
	assign bit_idx = {~i_byte, 3'b000};

	always_comb begin
		if (SEL == 0) begin
			o_byte = SBOX0_TABLE[bit_idx +: 8];
		end else begin
			o_byte = SBOX1_TABLE[bit_idx +: 8]; // S1.
		end
	end

endmodule

// File: logic/zuc_lfsr.sv
`timescale 1ns/1ns

module zuc_lfsr (
	input  logic                      i_clk,
	input  logic                      i_rst,
	input  logic [zuc_pkg::KEY_W-1:0] i_key,
	input  logic [zuc_pkg::KEY_W-1:0] i_iv,
	input  zuc_pkg::step_ctrl_t       i_step_ctrl,
	input  zuc_pkg::word_t            i_w,
	output zuc_pkg::brc_t             o_brc
);

	zuc_pkg::cell_t [zuc_pkg::NUM_CELLS-1:0] r_s;
	zuc_pkg::cell_t [zuc_pkg::NUM_CELLS-1:0] load_cells;

	zuc_pkg::cell_t v1;
	zuc_pkg::cell_t v2;
	zuc_pkg::cell_t v3;
	zuc_pkg::cell_t v4;
	zuc_pkg::cell_t v5;
	zuc_pkg::cell_t fb;
	zuc_pkg::cell_t s16;

	// Key byte 0 is the most significant byte of i_key.
	always_comb begin
		for (int i = 0; i < zuc_pkg::NUM_CELLS; i++) begin
			load_cells[i] = {i_key[zuc_pkg::KEY_W-1-8*i -: 8],
				zuc_pkg::LOAD_CONST[i],
				i_iv[zuc_pkg::KEY_W-1-8*i -: 8]};
		end
	end

	// 2^15 s15 + 2^17 s13 + 2^21 s10 + 2^20 s4 + (1 + 2^8) s0.
	assign v1 = zuc_pkg::add_mod(r_s[0], zuc_pkg::rotl31(r_s[0], 8));
	assign v2 = zuc_pkg::add_mod(v1, zuc_pkg::rotl31(r_s[4], 20));
	assign v3 = zuc_pkg::add_mod(v2, zuc_pkg::rotl31(r_s[10], 21));
	assign v4 = zuc_pkg::add_mod(v3, zuc_pkg::rotl31(r_s[13], 17));
	assign v5 = zuc_pkg::add_mod(v4, zuc_pkg::rotl31(r_s[15], 15));

	assign fb  = i_step_ctrl.init_mode ? zuc_pkg::add_mod(v5, i_w[31:1]) : v5;
	assign s16 = (fb == '0) ? zuc_pkg::CELL_MAX : fb; // Zero maps to 2^31-1.

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			r_s <= '0;
		end else if (i_step_ctrl.load) begin
			r_s <= load_cells;
		end else if (i_step_ctrl.step) begin
			r_s <= {s16, r_s[zuc_pkg::NUM_CELLS-1:1]};
		end
	end

	// Bit reorganisation.
	assign o_brc.x0 = {r_s[15][30:15], r_s[14][15:0]};
	assign o_brc.x1 = {r_s[11][15:0], r_s[9][30:15]};
	assign o_brc.x2 = {r_s[7][15:0], r_s[5][30:15]};
	assign o_brc.x3 = {r_s[2][15:0], r_s[0][30:15]};

endmodule

// File: logic/zuc_nonlinear_f.sv
`timescale 1ns/1ns

module zuc_nonlinear_f (
	input  logic                i_clk,
	input  logic                i_rst,
	input  zuc_pkg::step_ctrl_t i_step_ctrl,
	input  zuc_pkg::brc_t       i_brc,
	output zuc_pkg::word_t      o_w,
	output zuc_pkg::word_t      o_z
);

	zuc_pkg::word_t r_r1;
	zuc_pkg::word_t r_r2;
	zuc_pkg::word_t w;
	zuc_pkg::word_t w1;
	zuc_pkg::word_t w2;
	zuc_pkg::word_t u;
	zuc_pkg::word_t v;
	zuc_pkg::word_t r1_next;
	zuc_pkg::word_t r2_next;

	assign w   = (i_brc.x0 ^ r_r1) + r_r2;
	assign o_w = w;
	assign o_z = w ^ i_brc.x3;

	assign w1 = r_r1 + i_brc.x1;
	assign w2 = r_r2 ^ i_brc.x2;
	assign u  = zuc_pkg::l1({w1[15:0], w2[31:16]});
	assign v  = zuc_pkg::l2({w2[15:0], w1[31:16]});

	// S0 on the high byte, then alternating with S1.
	for (genvar g = 0; g < 4; g++) begin : g_sbox
		zuc_sbox #(
			.SEL(g % 2)
		) u_sbox_r1 (
			.i_byte(u[31-8*g -: 8]),
			.o_byte(r1_next[31-8*g -: 8])
		);

		zuc_sbox #(
			.SEL(g % 2)
		) u_sbox_r2 (
			.i_byte(v[31-8*g -: 8]),
			.o_byte(r2_next[31-8*g -: 8])
		);
	end

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			r_r1 <= '0;
			r_r2 <= '0;
		end else if (i_step_ctrl.load) begin
			r_r1 <= '0;
			r_r2 <= '0;
		end else if (i_step_ctrl.step) begin
			r_r1 <= r1_next;
			r_r2 <= r2_next;
		end
	end

endmodule

// File: logic/zuc_ctrl.sv
`timescale 1ns/1ns

// i_init loads on edge 0, edges 1 to 32 run the init rounds and edge 33 is the
// discarded work step. The first word is captured on edge 34, which is
// zuc_pkg::FIRST_WORD_LAT.
module zuc_ctrl (
	input  logic                i_clk,
	input  logic                i_rst,
	input  logic                i_init,
	input  logic                i_ready,
	input  zuc_pkg::word_t      i_z,
	output zuc_pkg::step_ctrl_t o_step_ctrl,
	output logic                o_valid,
	output zuc_pkg::word_t      o_data
);

	zuc_pkg::phase_t r_phase;
	logic [zuc_pkg::ROUND_CNT_W-1:0] r_round;
	logic r_valid;
	zuc_pkg::word_t r_data;
	logic stream_step;

	// Output register empty or being taken this cycle.
	assign stream_step = (r_phase == zuc_pkg::PH_STREAM) && (!r_valid || i_ready) && !i_init;

	always_comb begin
		o_step_ctrl = '0;
		o_step_ctrl.load = i_init;
		o_step_ctrl.step = !i_init && ((r_phase == zuc_pkg::PH_INIT) ||
			(r_phase == zuc_pkg::PH_DISCARD) || stream_step);
		o_step_ctrl.init_mode = !i_init && (r_phase == zuc_pkg::PH_INIT);
	end

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			r_phase <= zuc_pkg::PH_IDLE;
			r_round <= '0;
			r_valid <= 1'b0;
		end else if (i_init) begin
			r_phase <= zuc_pkg::PH_INIT; // Restart from any phase.
			r_round <= '0;
			r_valid <= 1'b0;
		end else begin
			case (r_phase)
				zuc_pkg::PH_INIT: begin
					r_round <= r_round + 1'b1;
					if (r_round == zuc_pkg::ROUND_CNT_W'(zuc_pkg::INIT_ROUNDS - 1)) begin
						r_phase <= zuc_pkg::PH_DISCARD;
					end
				end
				zuc_pkg::PH_DISCARD: begin
					r_phase <= zuc_pkg::PH_STREAM;
				end
				zuc_pkg::PH_STREAM: begin
					if (stream_step) begin
						r_valid <= 1'b1;
					end
				end
				default: begin
					r_phase <= zuc_pkg::PH_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge i_clk) begin
		if (stream_step) begin
			r_data <= i_z;
		end
	end

	assign o_valid = r_valid;
	assign o_data  = r_data;

endmodule

// File: logic/zuc_core.sv
`timescale 1ns/1ns

module zuc_core (
	input  logic                      i_clk,
	input  logic                      i_rst,
	input  logic                      i_init,
	input  logic [zuc_pkg::KEY_W-1:0] i_key,
	input  logic [zuc_pkg::KEY_W-1:0] i_iv,
	input  logic                      i_ready,
	output logic                      o_valid,
	output zuc_pkg::word_t            o_data
);

	zuc_pkg::step_ctrl_t step_ctrl;
	zuc_pkg::brc_t       brc;
	zuc_pkg::word_t      w;
	zuc_pkg::word_t      z;

	zuc_ctrl u_ctrl (
		.i_clk      (i_clk),
		.i_rst      (i_rst),
		.i_init     (i_init),
		.i_ready    (i_ready),
		.i_z        (z),
		.o_step_ctrl(step_ctrl),
		.o_valid    (o_valid),
		.o_data     (o_data)
	);

	zuc_lfsr u_lfsr (
		.i_clk      (i_clk),
		.i_rst      (i_rst),
		.i_key      (i_key),
		.i_iv       (i_iv),
		.i_step_ctrl(step_ctrl),
		.i_w        (w),
		.o_brc      (brc)
	);

	// W feeds the LFSR during init, Z goes to the output register.
	zuc_nonlinear_f u_nonlinear_f (
		.i_clk      (i_clk),
		.i_rst      (i_rst),
		.i_step_ctrl(step_ctrl),
		.i_brc      (brc),
		.o_w        (w),
		.o_z        (z)
	);

endmodule

// File: testbench/zuc_core_asserts.sv
`timescale 1ns/1ns

module zuc_core_asserts (
	input logic           i_clk,
	input logic           i_rst,
	input logic           i_init,
	input logic           i_ready,
	input logic           i_valid,
	input zuc_pkg::word_t i_data
);

	logic       r_armed;
	logic [7:0] r_since_init;
	int         fail_count = 0;

	// Counts edges since the one that sampled i_init, saturating.
	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			r_armed      <= 1'b0;
			r_since_init <= '0;
		end else if (i_init) begin
			r_armed      <= 1'b1;
			r_since_init <= '0;
		end else if (r_since_init != '1) begin
			r_since_init <= r_since_init + 8'd1;
		end
	end

	a_quiet_until_init: assert property (@(posedge i_clk)
		(i_rst || !r_armed) |-> !i_valid)
	else begin
		$error("o_valid went high before any i_init");
		fail_count++;
	end

	a_first_word_lat: assert property (@(posedge i_clk) disable iff (i_rst)
		$rose(i_valid) |-> (r_since_init == 8'(zuc_pkg::FIRST_WORD_LAT)))
	else begin
		$error("o_valid rose at the wrong distance from i_init");
		fail_count++;
	end

	a_first_word_due: assert property (@(posedge i_clk) disable iff (i_rst)
		(r_armed && r_since_init == 8'(zuc_pkg::FIRST_WORD_LAT)) |-> i_valid)
	else begin
		$error("first word missing at FIRST_WORD_LAT");
		fail_count++;
	end

	a_hold_stalled: assert property (@(posedge i_clk) disable iff (i_rst)
		(i_valid && !i_ready && !i_init) |=> (i_valid && $stable(i_data)))
	else begin
		$error("o_data or o_valid changed while stalled");
		fail_count++;
	end

	a_init_clears: assert property (@(posedge i_clk) disable iff (i_rst)
		i_init |=> !i_valid)
	else begin
		$error("o_valid not cleared by i_init");
		fail_count++;
	end

	a_back_to_back: assert property (@(posedge i_clk) disable iff (i_rst)
		(i_valid && i_ready && !i_init) |=> i_valid)
	else begin
		$error("gap in the stream under continuous i_ready");
		fail_count++;
	end

endmodule

bind zuc_core zuc_core_asserts u_asserts (
	.i_clk  (i_clk),
	.i_rst  (i_rst),
	.i_init (i_init),
	.i_ready(i_ready),
	.i_valid(o_valid),
	.i_data (o_data)
);

// File: testbench/tb_zuc_core.sv
`timescale 1ns/1ns

module tb_zuc_core;

	localparam int CLK_PERIOD      = 40;
	localparam int DRIVE_DELAY     = 2;
	localparam int WORD_WAIT       = zuc_pkg::FIRST_WORD_LAT + 64;
	localparam int WATCHDOG_CYCLES = 8 * WORD_WAIT;

	localparam logic [zuc_pkg::KEY_W-1:0] ALL_ZERO = '0;
	localparam logic [zuc_pkg::KEY_W-1:0] ALL_ONES = '1;

	// Published keystream vectors.
	localparam zuc_pkg::word_t ZERO_Z0 = 32'h27bede74;
	localparam zuc_pkg::word_t ZERO_Z1 = 32'h018082da;
	localparam zuc_pkg::word_t ONES_Z0 = 32'h0657cfa0;
	localparam zuc_pkg::word_t ONES_Z1 = 32'h7096398b;

	logic                      i_clk = 1'b0;
	logic                      i_rst;
	logic                      i_init;
	logic [zuc_pkg::KEY_W-1:0] i_key;
	logic [zuc_pkg::KEY_W-1:0] i_iv;
	logic                      i_ready;
	logic                      o_valid;
	zuc_pkg::word_t            o_data;

	zuc_pkg::word_t rx_words[$];
	int             value_errors;
	int             tests_run;
	int             tests_failed;
	int             errors_at_start;
	int             asserts_at_start;

	zuc_core u_dut (
		.i_clk  (i_clk),
		.i_rst  (i_rst),
		.i_init (i_init),
		.i_key  (i_key),
		.i_iv   (i_iv),
		.i_ready(i_ready),
		.o_valid(o_valid),
		.o_data (o_data)
	);

	always #(CLK_PERIOD / 2) i_clk = ~i_clk;

	task automatic drive_after_edge();
		@(posedge i_clk);
		#DRIVE_DELAY;
	endtask

	// i_init is sampled on the second edge after this call starts.
	task automatic start_cipher(input logic [zuc_pkg::KEY_W-1:0] key,
		input logic [zuc_pkg::KEY_W-1:0] iv);
		drive_after_edge();
		i_key   = key;
		i_iv    = iv;
		i_init  = 1'b1;
		i_ready = 1'b0;
		drive_after_edge();
		i_init = 1'b0;
	endtask

	// Transfers are seen at the falling edge before the accepting edge.
	task automatic receive_words(input int count, input bit random_ready);
		int idle;
		rx_words.delete();
		idle = 0;
		while (rx_words.size() < count && idle < WORD_WAIT) begin
			@(negedge i_clk);
			if (o_valid && i_ready) begin
				rx_words.push_back(o_data);
				idle = 0;
			end else begin
				idle++;
			end
			drive_after_edge();
			i_ready = random_ready ? 1'($urandom_range(0, 1)) : 1'b1;
		end
		if (rx_words.size() < count) begin
			$display("Gave up waiting at %0t ns: %0d of %0d words arrived", $time,
				rx_words.size(), count);
			value_errors++;
		end
	endtask

	task automatic check_word(input int idx, input zuc_pkg::word_t expected);
		if (idx < rx_words.size() && rx_words[idx] !== expected) begin
			$display("ERROR %0t ns: word %0d is %08h, expected %08h", $time, idx,
				rx_words[idx], expected);
			value_errors++;
		end
	endtask

	task automatic begin_test();
		errors_at_start  = value_errors;
		asserts_at_start = u_dut.u_asserts.fail_count;
	endtask

	task automatic end_test(input string name);
		int errs;
		errs = value_errors - errors_at_start + u_dut.u_asserts.fail_count - asserts_at_start;
		tests_run++;
		if (errs == 0) begin
			$display("Test %0d (%s): ok", tests_run, name);
		end else begin
			$display("Test %0d (%s): failed with %0d errors", tests_run, name, errs);
			tests_failed++;
		end
	endtask

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Simulation timed out after %0d cycles", WATCHDOG_CYCLES);
		$display("*** TEST FAILED ***");
		$finish;
	end

	initial begin
		void'($urandom(26075));
		value_errors = 0;
		tests_run    = 0;
		tests_failed = 0;
		i_rst   = 1'b1;
		i_init  = 1'b0;
		i_key   = '0;
		i_iv    = '0;
		i_ready = 1'b0;

		begin_test();
		repeat (3) @(posedge i_clk);
		#DRIVE_DELAY;
		i_rst = 1'b0;
		repeat (4) drive_after_edge(); // Idle, no i_init yet.
		end_test("reset");

		begin_test();
		start_cipher(ALL_ZERO, ALL_ZERO);
		receive_words(2, 1'b0);
		check_word(0, ZERO_Z0);
		check_word(1, ZERO_Z1);
		end_test("zero key and IV");

		begin_test();
		start_cipher(ALL_ONES, ALL_ONES);
		receive_words(2, 1'b1);
		check_word(0, ONES_Z0);
		check_word(1, ONES_Z1);
		end_test("all-ones key and IV, random ready");

		begin_test();
		start_cipher(ALL_ZERO, ALL_ZERO);
		receive_words(5, 1'b0);
		check_word(0, ZERO_Z0);
		start_cipher(ALL_ZERO, ALL_ZERO); // Lands while o_valid is high.
		receive_words(1, 1'b0);
		check_word(0, ZERO_Z0);
		end_test("re-init mid-stream");

		begin_test();
		start_cipher(ALL_ZERO, ALL_ZERO);
		receive_words(17, 1'b0);
		check_word(0, ZERO_Z0);
		check_word(1, ZERO_Z1);
		end_test("continuous ready");

		$display("Tests run: %0d, failed: %0d, value errors: %0d, assertion failures: %0d",
			tests_run, tests_failed, value_errors, u_dut.u_asserts.fail_count);
		if (tests_failed == 0 && u_dut.u_asserts.fail_count == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

// File: flist.f
+incdir+logic
logic/zuc_pkg.sv
logic/zuc_sbox.sv
logic/zuc_lfsr.sv
logic/zuc_nonlinear_f.sv
logic/zuc_ctrl.sv
logic/zuc_core.sv
testbench/zuc_core_asserts.sv
testbench/tb_zuc_core.sv

// File: run_sim.sh
#!/bin/sh
# Builds the ZUC keystream testbench with Verilator and runs it.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_zuc_core \
	-f flist.f \
	-o tb_zuc_core

# Keep running after the first assertion error so the testbench can report.
sim_out=$(./obj_dir/tb_zuc_core +verilator+error+limit+1000)
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -q -F '*** TEST PASSED ***'; then
	exit 0
else
	echo "Simulation did not pass."
	exit 1
fi
